// ==== verilog/hist_pkg.sv ====
package hist_pkg;

  // Sizes shared by the RAM, the update pipeline, the readout and the testbench

  // A bin index selects one counter in the RAM
  localparam int BIN_W = 6;

  // One RAM word per bin
  localparam int NUM_BINS = 1 << BIN_W;

  // Counters are narrow so that saturation can be reached quickly
  localparam int COUNT_W = 8;

  // Counts stick at all ones
  localparam logic [COUNT_W-1:0] COUNT_MAX = '1;

  // Memory stage plus output register
  localparam int RAM_LATENCY = 2;

endpackage

// ==== verilog/tdp_ram_write_first.sv ====
`timescale 1ns/1ps

module tdp_ram_write_first (
  input  logic                         clka,   // Both ports run on this clock
  input  logic                         rsta,   // Clears the output registers and leaves memory alone
  input  logic                         ena,    // Port A access enable
  input  logic                         enb,    // Port B access enable
  input  logic                         wea,    // Port A write when enabled
  input  logic                         web,    // Port B write when enabled
  input  logic [hist_pkg::BIN_W-1:0]   addra,
  input  logic [hist_pkg::BIN_W-1:0]   addrb,
  input  logic [hist_pkg::COUNT_W-1:0] dina,
  input  logic [hist_pkg::COUNT_W-1:0] dinb,
  output logic [hist_pkg::COUNT_W-1:0] douta,  // Registered port A data
  output logic [hist_pkg::COUNT_W-1:0] doutb   // Registered port B data
);
  import hist_pkg::*;

  logic [COUNT_W-1:0] mem [NUM_BINS];  // Counter storage
  logic [COUNT_W-1:0] ram_data_a;      // Port A memory stage
  logic [COUNT_W-1:0] ram_data_b;      // Port B memory stage

  // Every bin starts at zero so the first histogram needs no clearing dump
  initial begin
    for (int i = 0; i < NUM_BINS; i++) begin
      mem[i] = '0;
    end
    ram_data_a = '0;
    ram_data_b = '0;
  end

  // Write-first on port A so a write shows its own data on the port
  always @(posedge clka) begin
    if (ena) begin
      if (wea) begin
        mem[addra] <= dina;
        ram_data_a <= dina;
      end else begin
        ram_data_a <= mem[addra];  // Old contents even if port B writes here now
      end
    end
  end

  // Port B behaves the same way
  always @(posedge clka) begin
    if (enb) begin
      if (web) begin
        mem[addrb] <= dinb;
        ram_data_b <= dinb;
      end else begin
        ram_data_b <= mem[addrb];
      end
    end
  end

  // The output register loads every cycle which gives the fixed two-cycle read
  always_ff @(posedge clka) begin
    if (rsta) begin
      douta <= '0;
      doutb <= '0;
    end else begin
      douta <= ram_data_a;
      doutb <= ram_data_b;
    end
  end

endmodule

// ==== verilog/hist_update.sv ====
`timescale 1ns/1ps

module hist_update (
  input  logic                         clka,
  input  logic                         rsta,
  input  logic                         sample_valid,  // One strobe per sample
  input  logic                         dump_busy,     // Samples are dropped while this is high
  input  logic [hist_pkg::BIN_W-1:0]   sample_bin,
  input  logic [hist_pkg::COUNT_W-1:0] douta,         // Stored count of the bin in the last stage
  output logic                         upd_rd_en,
  output logic                         upd_wr_en,
  output logic                         upd_idle,      // No sample left in the stages
  output logic [hist_pkg::BIN_W-1:0]   upd_rd_addr,
  output logic [hist_pkg::BIN_W-1:0]   upd_wr_addr,
  output logic [hist_pkg::COUNT_W-1:0] upd_wr_data
);
  import hist_pkg::*;

  // Stage 0 is the accepted sample itself and stages 1 to RAM_LATENCY are registers
  logic                     accept;
  logic [RAM_LATENCY:1]     stg_v_q;
  logic [BIN_W-1:0]         stg_bin_q [1:RAM_LATENCY];

  // History of the last RAM_LATENCY writes with entry 1 the most recent
  logic [RAM_LATENCY:1]     fwd_v_q;
  logic [BIN_W-1:0]         fwd_bin_q [1:RAM_LATENCY];
  logic [COUNT_W-1:0]       fwd_data_q [1:RAM_LATENCY];

  logic                     last_v;      // Sample whose old count is on douta
  logic [BIN_W-1:0]         last_bin;
  logic [COUNT_W-1:0]       base_count;  // Old count after forwarding
  logic [COUNT_W-1:0]       next_count;  // Incremented and saturated

  assign accept      = sample_valid && !dump_busy;
  assign upd_rd_en   = accept;      // The read goes out in the cycle of acceptance
  assign upd_rd_addr = sample_bin;

  assign last_v   = stg_v_q[RAM_LATENCY];
  assign last_bin = stg_bin_q[RAM_LATENCY];

  // A read misses the writes issued in its own cycle and the RAM_LATENCY-1 after it
  // Those writes belong to the preceding samples and are taken from the history instead
  always_comb begin
    base_count = douta;
    for (int i = RAM_LATENCY; i >= 1; i--) begin
      if (fwd_v_q[i] && (fwd_bin_q[i] == last_bin)) begin
        base_count = fwd_data_q[i];  // Later iterations are newer and override
      end
    end
  end

  // Saturating increment
  assign next_count = (base_count == COUNT_MAX) ? base_count : base_count + 1'b1;

  // The write-back leaves in the same cycle as the old count arrives
  assign upd_wr_en   = last_v;
  assign upd_wr_addr = last_bin;
  assign upd_wr_data = next_count;

  assign upd_idle = ~|stg_v_q;  // The readout waits on this before it starts reading

  // Valid bits of the stages and of the write history
  always_ff @(posedge clka) begin
    if (rsta) begin
      stg_v_q <= '0;
      fwd_v_q <= '0;
    end else begin
      stg_v_q[1] <= accept;
      fwd_v_q[1] <= last_v;  // Only real write-backs enter the history
      for (int i = 2; i <= RAM_LATENCY; i++) begin
        stg_v_q[i] <= stg_v_q[i-1];
        fwd_v_q[i] <= fwd_v_q[i-1];
      end
    end
  end

  // Bins and counts only matter where the matching valid bit is set
  always_ff @(posedge clka) begin
    stg_bin_q[1]  <= sample_bin;
    fwd_bin_q[1]  <= last_bin;
    fwd_data_q[1] <= next_count;
    for (int i = 2; i <= RAM_LATENCY; i++) begin
      stg_bin_q[i]  <= stg_bin_q[i-1];
      fwd_bin_q[i]  <= fwd_bin_q[i-1];
      fwd_data_q[i] <= fwd_data_q[i-1];
    end
  end

endmodule

// ==== verilog/hist_readout.sv ====
`timescale 1ns/1ps

module hist_readout (
  input  logic                         clka,
  input  logic                         rsta,
  input  logic                         dump_start,   // Pulse that requests a full dump
  input  logic                         upd_idle,     // Update pipeline holds no sample
  input  logic                         upd_rd_en,
  input  logic                         upd_wr_en,
  input  logic [hist_pkg::BIN_W-1:0]   upd_rd_addr,
  input  logic [hist_pkg::BIN_W-1:0]   upd_wr_addr,
  input  logic [hist_pkg::COUNT_W-1:0] upd_wr_data,
  input  logic [hist_pkg::COUNT_W-1:0] douta,
  output logic                         dump_busy,    // High from the cycle after the start
  output logic                         dump_valid,   // One strobe per bin read out
  output logic                         ena,
  output logic                         wea,
  output logic                         enb,
  output logic                         web,
  output logic [hist_pkg::BIN_W-1:0]   addra,
  output logic [hist_pkg::BIN_W-1:0]   addrb,
  output logic [hist_pkg::BIN_W-1:0]   dump_bin,
  output logic [hist_pkg::COUNT_W-1:0] dina,
  output logic [hist_pkg::COUNT_W-1:0] dinb,
  output logic [hist_pkg::COUNT_W-1:0] dump_count
);
  import hist_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_DRAIN, ST_SCAN} state_t;

  state_t                 state_q;
  state_t                 state_d;
  logic [BIN_W-1:0]       scan_bin_q;               // Next bin to read
  logic                   rd_done_q;                // All bins have been read
  logic                   scan_rd;                  // Dump read on port A this cycle
  logic                   last_rd;
  logic                   last_out;
  logic [RAM_LATENCY-1:0] dl_v_q;                   // Tracks reads until douta holds them
  logic [BIN_W-1:0]       dl_bin_q [RAM_LATENCY];

  assign dump_busy = (state_q != ST_IDLE);

  // Reads begin once the pipeline has drained and stop after the last bin
  assign scan_rd  = dump_busy && upd_idle && !rd_done_q;
  assign last_rd  = scan_rd && (scan_bin_q == BIN_W'(NUM_BINS - 1));

  assign dump_valid = dl_v_q[RAM_LATENCY-1];
  assign dump_bin   = dl_bin_q[RAM_LATENCY-1];
  assign dump_count = douta;  // Read data of the bin in the last delay stage
  assign last_out   = dump_valid && (dump_bin == BIN_W'(NUM_BINS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (dump_start) begin
          state_d = ST_DRAIN;  // A start while busy is simply not looked at
        end
      end
      ST_DRAIN: begin
        if (upd_idle) begin
          state_d = ST_SCAN;   // The first read already goes out in this cycle
        end
      end
      ST_SCAN: begin
        if (last_out) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clka) begin
    if (rsta) begin
      state_q    <= ST_IDLE;
      scan_bin_q <= '0;
      rd_done_q  <= 1'b0;
      dl_v_q     <= '0;
    end else begin
      state_q <= state_d;
      if (scan_rd) begin
        scan_bin_q <= scan_bin_q + 1'b1;  // Wraps back to bin 0 after the last read
      end
      if (last_rd) begin
        rd_done_q <= 1'b1;
      end else if (!dump_busy) begin
        rd_done_q <= 1'b0;
      end
      dl_v_q[0] <= scan_rd;
      for (int i = 1; i < RAM_LATENCY; i++) begin
        dl_v_q[i] <= dl_v_q[i-1];
      end
    end
  end

  always_ff @(posedge clka) begin
    dl_bin_q[0] <= scan_bin_q;
    for (int i = 1; i < RAM_LATENCY; i++) begin
      dl_bin_q[i] <= dl_bin_q[i-1];
    end
  end

  // Dump and update traffic never overlap so a plain select is enough
  assign ena   = scan_rd || upd_rd_en;
  assign addra = scan_rd ? scan_bin_q : upd_rd_addr;
  assign wea   = 1'b0;                          // Port A only ever reads
  assign dina  = '0;

  // Each dumped bin is cleared as it leaves so reads and writes never share an address
  assign enb   = dump_valid || upd_wr_en;
  assign web   = enb;                           // Port B only ever writes
  assign addrb = dump_valid ? dump_bin : upd_wr_addr;
  assign dinb  = dump_valid ? '0 : upd_wr_data;

endmodule

// ==== verilog/hist_top.sv ====
`timescale 1ns/1ps

module hist_top (
  input  logic                         clka,
  input  logic                         rsta,
  input  logic                         sample_valid,  // Strobe with one bin index
  input  logic                         dump_start,    // Pulse that starts a dump
  input  logic [hist_pkg::BIN_W-1:0]   sample_bin,
  output logic                         dump_busy,     // Samples are dropped while high
  output logic                         dump_valid,
  output logic [hist_pkg::BIN_W-1:0]   dump_bin,
  output logic [hist_pkg::COUNT_W-1:0] dump_count
);
  import hist_pkg::*;

  // Update requests toward the readout
  logic               upd_rd_en;
  logic               upd_wr_en;
  logic               upd_idle;
  logic [BIN_W-1:0]   upd_rd_addr;
  logic [BIN_W-1:0]   upd_wr_addr;
  logic [COUNT_W-1:0] upd_wr_data;

  // RAM port controls that the readout owns
  logic               ena;
  logic               wea;
  logic               enb;
  logic               web;
  logic [BIN_W-1:0]   addra;
  logic [BIN_W-1:0]   addrb;
  logic [COUNT_W-1:0] dina;
  logic [COUNT_W-1:0] dinb;
  logic [COUNT_W-1:0] douta;  // Feeds both the update and the dump

  hist_update u_update (
    .clka         (clka),
    .rsta         (rsta),
    .sample_valid (sample_valid),
    .dump_busy    (dump_busy),
    .sample_bin   (sample_bin),
    .douta        (douta),
    .upd_rd_en    (upd_rd_en),
    .upd_wr_en    (upd_wr_en),
    .upd_idle     (upd_idle),
    .upd_rd_addr  (upd_rd_addr),
    .upd_wr_addr  (upd_wr_addr),
    .upd_wr_data  (upd_wr_data)
  );

  hist_readout u_readout (
    .clka        (clka),
    .rsta        (rsta),
    .dump_start  (dump_start),
    .upd_idle    (upd_idle),
    .upd_rd_en   (upd_rd_en),
    .upd_wr_en   (upd_wr_en),
    .upd_rd_addr (upd_rd_addr),
    .upd_wr_addr (upd_wr_addr),
    .upd_wr_data (upd_wr_data),
    .douta       (douta),
    .dump_busy   (dump_busy),
    .dump_valid  (dump_valid),
    .ena         (ena),
    .wea         (wea),
    .enb         (enb),
    .web         (web),
    .addra       (addra),
    .addrb       (addrb),
    .dump_bin    (dump_bin),
    .dina        (dina),
    .dinb        (dinb),
    .dump_count  (dump_count)
  );

  // Port B only writes so its read data has no consumer
  tdp_ram_write_first u_ram (
    .clka  (clka),
    .rsta  (rsta),
    .ena   (ena),
    .enb   (enb),
    .wea   (wea),
    .web   (web),
    .addra (addra),
    .addrb (addrb),
    .dina  (dina),
    .dinb  (dinb),
    .douta (douta),
    .doutb ()
  );

endmodule

// ==== tests/hist_properties.sv ====
`timescale 1ns/1ps

module hist_properties (
  input logic                       clka,
  input logic                       rsta,
  input logic                       dump_busy,
  input logic                       dump_valid,
  input logic                       ena,
  input logic                       wea,
  input logic                       enb,
  input logic                       web,
  input logic [hist_pkg::BIN_W-1:0] addra,
  input logic [hist_pkg::BIN_W-1:0] addrb,
  input logic [hist_pkg::BIN_W-1:0] dump_bin
);
  import hist_pkg::*;

  int fail_count = 0;  // Read by the testbench at the end of the run

  // Bin outputs come only from a running dump
  valid_in_dump: assert property (@(posedge clka) disable iff (rsta)
    dump_valid |-> dump_busy)
    else begin
      fail_count++;
      $error("dump_valid high while dump_busy is low");
    end

  // The scan never skips or repeats a bin
  bin_order: assert property (@(posedge clka) disable iff (rsta)
    (dump_valid && $past(dump_valid)) |-> (dump_bin == BIN_W'($past(dump_bin) + 1'b1)))
    else begin
      fail_count++;
      $error("dump_bin 0x%02h does not follow the previous bin", dump_bin);
    end

  busy_after_reset: assert property (@(posedge clka) rsta |=> !dump_busy)
    else begin
      fail_count++;
      $error("dump_busy high in the cycle after reset");
    end

  // Only port B writes and during a dump the cleared bin trails the bin being read
  one_writer: assert property (@(posedge clka) disable iff (rsta)
    (ena && enb && web) |-> (!wea && (!dump_busy || addra != addrb)))
    else begin
      fail_count++;
      $error("RAM write collides with the other port at address 0x%02h", addrb);
    end

endmodule

bind hist_readout hist_properties u_properties (
  .clka       (clka),
  .rsta       (rsta),
  .dump_busy  (dump_busy),
  .dump_valid (dump_valid),
  .ena        (ena),
  .wea        (wea),
  .enb        (enb),
  .web        (web),
  .addra      (addra),
  .addrb      (addrb),
  .dump_bin   (dump_bin)
);

// ==== tests/hist_tb.sv ====
`timescale 1ns/1ps

module hist_tb;
  import hist_pkg::*;

  localparam logic [1:0] K_BURST  = 2'd0;  // Samples to the bin of the row
  localparam logic [1:0] K_RANDOM = 2'd1;  // Samples to bins from the xorshift sequence
  localparam logic [1:0] K_DUMP   = 2'd2;  // Dump, with the row's samples offered while it runs
  localparam int WAIT_LIMIT = 400;        // Cycles allowed for dump_busy to change

  typedef struct {
    logic [1:0]       kind;
    logic [BIN_W-1:0] bin;
    int               count;  // Number of samples
    int               gap;    // Idle cycles after each sample
  } row_t;

  logic               clka;
  logic               rsta;
  logic               sample_valid;
  logic               dump_start;
  logic [BIN_W-1:0]   sample_bin;
  logic               dump_busy;
  logic               dump_valid;
  logic [BIN_W-1:0]   dump_bin;
  logic [COUNT_W-1:0] dump_count;

  row_t               rows [$];
  logic [COUNT_W-1:0] model [NUM_BINS];  // Reference counts of accepted samples
  logic [COUNT_W-1:0] snap [NUM_BINS];   // Counts expected from the running dump
  logic [BIN_W-1:0]   exp_bin;           // Next bin the dump should return
  int                 seen;              // Dump outputs so far in this dump
  logic               fall_due;          // The dump has just returned its last bin
  logic [31:0]        rng_state;
  int                 value_errors;
  int                 other_errors;
  logic               timed_out;

  hist_top uut (
    .clka         (clka),
    .rsta         (rsta),
    .sample_valid (sample_valid),
    .dump_start   (dump_start),
    .sample_bin   (sample_bin),
    .dump_busy    (dump_busy),
    .dump_valid   (dump_valid),
    .dump_bin     (dump_bin),
    .dump_count   (dump_count)
  );

  always #2 clka = ~clka;  // 4 ns period

  task automatic step();
    @(posedge clka);
    #1;  // Inputs change well clear of the edge
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                             input logic [COUNT_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_bin(input string name, input logic [BIN_W-1:0] got,
                           input logic [BIN_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic add_row(input logic [1:0] kind, input logic [BIN_W-1:0] bin,
                         input int count, input int gap);
    row_t r;
    r.kind  = kind;
    r.bin   = bin;
    r.count = count;
    r.gap   = gap;
    rows.push_back(r);
  endtask

  // A sample counts only if dump_busy is low in the cycle it is offered
  task automatic send_sample(input logic [BIN_W-1:0] bin, input int gap);
    sample_valid = 1'b1;
    sample_bin   = bin;
    if (!dump_busy && model[bin] != COUNT_MAX) begin
      model[bin] = model[bin] + 1'b1;  // Counts stick at the maximum
    end
    step();
    sample_valid = 1'b0;
    repeat (gap) step();
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (dump_busy !== level && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (dump_busy !== level) begin
      other_errors++;
      timed_out = 1'b1;  // Later rows are skipped
      $display("Timeout: dump_busy did not go %s within %0d cycles",
               level ? "high" : "low", WAIT_LIMIT);
    end
  endtask

  task automatic run_dump(input row_t r);
    dump_start = 1'b1;
    step();
    dump_start = 1'b0;
    check_flag("dump_busy", dump_busy, 1'b1);  // Rises in the cycle after the start
    wait_busy(1'b1);
    if (!timed_out) begin
      for (int i = 0; i < NUM_BINS; i++) begin
        snap[i]  = model[i];
        model[i] = '0;  // Each bin is cleared as the dump passes it
      end
      exp_bin = '0;
      seen    = 0;
      for (int i = 0; i < r.count; i++) begin
        send_sample(r.bin, r.gap);  // Dropped while the dump runs
      end
      wait_busy(1'b0);
    end
    if (!timed_out && seen != NUM_BINS) begin
      other_errors++;
      $display("Dump returned %0d bins instead of %0d", seen, NUM_BINS);
    end
  endtask

  task automatic apply_row(input row_t r);
    case (r.kind)
      K_BURST: begin
        for (int i = 0; i < r.count; i++) begin
          send_sample(r.bin, r.gap);
        end
      end
      K_RANDOM: begin
        for (int i = 0; i < r.count; i++) begin
          rng_state = xorshift(rng_state);
          send_sample(rng_state[BIN_W-1:0], r.gap);
        end
      end
      default: run_dump(r);
    endcase
  endtask

  // Dump outputs are sampled mid-cycle where they are settled
  always @(negedge clka) begin
    if (fall_due) begin
      check_flag("dump_busy", dump_busy, 1'b0);  // Drops right after the last bin
      fall_due = 1'b0;
    end
    if (!rsta && dump_valid) begin
      if (seen >= NUM_BINS) begin
        other_errors++;
        $display("Dump output for bin %0d arrived after all bins were returned", dump_bin);
      end else begin
        check_bin("dump_bin", dump_bin, exp_bin);
        check_count("dump_count", dump_count, snap[exp_bin]);
      end
      exp_bin = exp_bin + 1'b1;
      seen++;
      if (seen == NUM_BINS) begin
        fall_due = 1'b1;
      end
    end
  end

  initial begin
    clka         = 1'b0;
    rsta         = 1'b1;
    sample_valid = 1'b0;
    sample_bin   = '0;
    dump_start   = 1'b0;
    rng_state    = 32'd41800;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    exp_bin      = '0;
    seen         = 0;
    fall_due     = 1'b0;
    for (int i = 0; i < NUM_BINS; i++) begin
      model[i] = '0;  // The RAM starts at zero
      snap[i]  = '0;
    end

    // Kind, bin, samples, gap
    add_row(K_BURST,  6'd3,    1, 5);  // Isolated samples with gaps
    add_row(K_BURST,  6'd17,   2, 4);
    add_row(K_BURST,  6'd40,   1, 3);
    add_row(K_DUMP,   6'd0,    0, 0);
    add_row(K_BURST,  6'd9,    6, 0);  // Back to back on one bin
    add_row(K_BURST,  6'd12,   1, 0);  // Two bins taking turns
    add_row(K_BURST,  6'd13,   1, 0);
    add_row(K_BURST,  6'd12,   1, 0);
    add_row(K_BURST,  6'd13,   1, 0);
    add_row(K_BURST,  6'd12,   1, 0);
    add_row(K_DUMP,   6'd0,    0, 0);
    add_row(K_BURST,  6'd50, 300, 0);  // Well past the maximum count
    add_row(K_DUMP,   6'd0,    0, 0);
    add_row(K_DUMP,   6'd0,    0, 0);  // Nothing left after a dump
    add_row(K_BURST,  6'd5,    3, 1);
    add_row(K_DUMP,   6'd22,  20, 1);  // Offered while busy
    add_row(K_DUMP,   6'd0,    0, 0);
    add_row(K_RANDOM, 6'd0,  200, 0);
    add_row(K_RANDOM, 6'd0,   40, 2);
    add_row(K_DUMP,   6'd0,    0, 0);

    repeat (4) @(posedge clka);
    #1;
    rsta = 1'b0;

    foreach (rows[i]) begin
      if (!timed_out) begin
        apply_row(rows[i]);
      end
    end
    repeat (4) step();

    if (uut.u_readout.u_properties.fail_count != 0) begin
      other_errors++;
      $display("Bound assertions failed %0d times", uut.u_readout.u_properties.fail_count);
    end

    $display("Closing count: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/hist_pkg.sv
verilog/tdp_ram_write_first.sv
verilog/hist_update.sv
verilog/hist_readout.sv
verilog/hist_top.sv
tests/hist_properties.sv
tests/hist_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the histogram testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module hist_tb -Mdir "$BUILD_DIR" -o hist_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/hist_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0
